//--- verilog/pixel_pkg.sv
/*
 * Shared definitions for the per-pixel update pipeline
 *   state word types and field accessors
 *   mode, dither, drive and operation enums
 *   set-mode presets and the default state word
 */
`default_nettype none

package pixel_pkg;

    // Stored state word and its fields
    typedef logic [15:0] pixel_state_t;
    typedef logic [3:0]  pixel_val_t;
    typedef logic [5:0]  frame_cnt_t;
    typedef logic [1:0]  mindrv_t;

    // Mode field in bits 15-12
    // Manual LUT only decodes bits 15-14
    // Bits 13-12 then hold the top of the source value
    typedef enum logic [3:0] {
        mode_ml_no_dither  = 4'b0000,
        mode_ml_error_diff = 4'b0100,
        mode_fm_no_dither  = 4'd8,
        mode_fm_bayer      = 4'd9,
        mode_fm_blue_noise = 4'd10
    } mode_e;

    typedef enum logic {
        base_manual_lut = 1'b0,
        base_fast_mono  = 1'b1
    } base_mode_e;

    typedef enum logic [1:0] {
        dither_none    = 2'd0,
        dither_bayer   = 2'd1,
        dither_bn_1bit = 2'd2,
        dither_ed_4bit = 2'd3
    } dither_e;

    // Panel drive code, 3 is never driven
    typedef enum logic [1:0] {
        no_drive    = 2'd0,
        drive_black = 2'd1,
        drive_white = 2'd2
    } drive_e;

    // Codes 2 and 3 are reserved
    typedef enum logic [1:0] {
        op_init   = 2'd0,
        op_normal = 2'd1
    } op_state_e;

    typedef enum logic [7:0] {
        op_ext_redraw  = 8'h01,
        op_ext_setmode = 8'h02
    } op_cmd_e;

    // op_param values of the set-mode command
    typedef enum logic [7:0] {
        setmode_ml_no_dither  = 8'd0,
        setmode_ml_error_diff = 8'd1,
        setmode_fm_no_dither  = 8'd2,
        setmode_fm_bayer      = 8'd3,
        setmode_fm_blue_noise = 8'd4
    } setmode_e;

    // Manual LUT, no dither, idle, target white
    localparam pixel_state_t default_state        = {mode_ml_no_dither, 12'h00F};
    localparam pixel_state_t preset_ml_error_diff = {mode_ml_error_diff, 12'h00F};
    // Fast mono presets start idle on a white previous pixel
    localparam pixel_state_t preset_fm_no_dither  = {mode_fm_no_dither, 12'h001};
    localparam pixel_state_t preset_fm_bayer      = {mode_fm_bayer, 12'h001};
    localparam pixel_state_t preset_fm_blue_noise = {mode_fm_blue_noise, 12'h001};

    // Frame counter, bits 9-4 in both modes
    function automatic frame_cnt_t state_framecnt(input pixel_state_t s);
        return s[9:4];
    endfunction

    // Manual LUT target value
    function automatic pixel_val_t state_target(input pixel_state_t s);
        return s[3:0];
    endfunction

    // Fast mono frame rate cap
    function automatic mindrv_t state_mindrv(input pixel_state_t s);
        return s[3:2];
    endfunction

    // Fast mono previous pixel, 1 is white
    function automatic logic state_prev(input pixel_state_t s);
        return s[0];
    endfunction

endpackage

`default_nettype wire

//--- verilog/pixel_mode_decode.sv
/*
 * Stage one of the pixel pipeline
 *   mode and dither decode with fast mono fallback
 *   external command decode and clear colour
 *   input value select and stage-one registers
 */
`default_nettype none

module pixel_mode_decode import pixel_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               in_valid,
    input  wire pixel_val_t   proc_p_or,
    input  wire               proc_p_bd,
    input  wire               proc_p_n1,
    input  wire pixel_val_t   proc_p_e4,
    input  wire pixel_state_t proc_bi,
    input  wire drive_e       proc_lut_rd,
    input  wire op_state_e    op_state,
    input  wire               op_valid,
    input  wire op_cmd_e      op_cmd,
    input  wire setmode_e     op_param,
    input  wire [7:0]         op_framecnt,
    output logic              s1_valid,
    output base_mode_e        s1_base,
    output pixel_val_t        s1_vin,
    output pixel_state_t      s1_bi,
    output drive_e            s1_lut_rd,
    output op_state_e         s1_state,
    output setmode_e          s1_param,
    output logic [7:0]        s1_framecnt,
    output logic              s1_force_clear,
    output logic              s1_update_req,
    output logic              s1_set_mode_apply
);

    base_mode_e base;
    dither_e    dither;
    pixel_val_t clear_color;
    pixel_val_t vin;

    // External commands
    wire redraw_en      = op_valid && (op_cmd == op_ext_redraw);
    wire set_mode_en    = op_valid && (op_cmd == op_ext_setmode);
    // Set-mode with a running frame count clears first, applies at count zero
    wire force_clear    = redraw_en || (set_mode_en && (op_framecnt != 8'd0));
    wire set_mode_apply = set_mode_en && (op_framecnt == 8'd0);

    // Mode decode
    always_comb begin
        base   = base_fast_mono;
        dither = dither_none;
        casez (proc_bi[15:12])
            4'b00??:            base = base_manual_lut;
            4'b01??: begin
                base   = base_manual_lut;
                dither = dither_ed_4bit;
            end
            mode_fm_bayer:      dither = dither_bayer;
            mode_fm_blue_noise: dither = dither_bn_1bit;
            // Fast mono no dither, stale fast grey and auto LUT codes
            default:            dither = dither_none;
        endcase
    end

    // Clear colour
    // Fast mono follows the global frame count, black on the late frames
    always_comb begin
        if (base == base_manual_lut) begin
            clear_color = 4'hF;
        end else if ((op_framecnt[4:3] == 2'b11) || op_framecnt[5]) begin
            clear_color = 4'h0;
        end else begin
            clear_color = 4'hF;
        end
    end

    // Input value
    always_comb begin
        if (force_clear) begin
            vin = clear_color;
        end else begin
            case (dither)
                dither_bayer:   vin = {4{proc_p_bd}};
                dither_bn_1bit: vin = {4{proc_p_n1}};
                dither_ed_4bit: vin = proc_p_e4;
                default:        vin = proc_p_or;
            endcase
        end
    end

    // Valid and command flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid          <= 1'b0;
            s1_force_clear    <= 1'b0;
            s1_update_req     <= 1'b0;
            s1_set_mode_apply <= 1'b0;
        end else begin
            s1_valid          <= in_valid;
            s1_force_clear    <= in_valid && force_clear;
            s1_update_req     <= in_valid && redraw_en;
            s1_set_mode_apply <= in_valid && set_mode_apply;
        end
    end

    // Pixel payload, captured with its valid strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_base     <= base;
            s1_vin      <= vin;
            s1_bi       <= proc_bi;
            s1_lut_rd   <= proc_lut_rd;
            s1_state    <= op_state;
            s1_param    <= op_param;
            s1_framecnt <= op_framecnt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/manual_lut_update.sv
/*
 * Manual LUT next state and drive
 *   waveform playback while the frame counter runs
 *   update start on redraw or forced clear
 */
`default_nettype none

module manual_lut_update import pixel_pkg::*; (
    input  wire pixel_state_t s1_bi,
    input  wire pixel_val_t   s1_vin,
    input  wire drive_e       s1_lut_rd,
    input  wire               s1_force_clear,
    input  wire               s1_update_req,
    input  wire frame_cnt_t   csr_lutframe,
    output pixel_state_t      ml_bo,
    output drive_e            ml_drive
);

    frame_cnt_t framecnt;
    frame_cnt_t framecnt_dec;

    assign framecnt     = state_framecnt(s1_bi);
    assign framecnt_dec = framecnt - 6'd1;

    always_comb begin
        if (framecnt != 6'd0) begin
            // Waveform in progress
            // Source and target hold, requests are ignored
            ml_drive = s1_lut_rd;
            ml_bo    = {s1_bi[15:10], framecnt_dec, s1_bi[3:0]};
        end else begin
            ml_drive = no_drive;
            if (s1_update_req || s1_force_clear) begin
                // Old target is what the panel shows now
                // It becomes the source of the new waveform
                ml_bo = {s1_bi[15:14], state_target(s1_bi), csr_lutframe, s1_vin};
            end else begin
                // Idle
                ml_bo = s1_bi;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fast_mono_update.sv
/*
 * Fast mono next state and drive
 *   black and white update with per-direction frame counts
 *   dynamic frame rate cap on reversals
 */
`default_nettype none

module fast_mono_update import pixel_pkg::*; #(
    parameter frame_cnt_t fastm_b2w_frames = 6'd9,
    parameter frame_cnt_t fastm_w2b_frames = 6'd9
) (
    input  wire pixel_state_t s1_bi,
    input  wire pixel_val_t   s1_vin,
    input  wire mindrv_t      csr_mindrv,
    output pixel_state_t      fm_bo,
    output drive_e            fm_drive
);

    frame_cnt_t framecnt;
    frame_cnt_t framecnt_dec;
    frame_cnt_t framecnt_2w;
    frame_cnt_t framecnt_2b;
    mindrv_t    mindrv;
    mindrv_t    mindrv_dec;
    logic       prev;
    logic       target;
    logic       change;
    drive_e     drive_to_input;
    drive_e     drive_prev;

    assign framecnt     = state_framecnt(s1_bi);
    assign framecnt_dec = framecnt - 6'd1;
    assign mindrv       = state_mindrv(s1_bi);
    // Cap counts down and stops at zero
    assign mindrv_dec   = (mindrv != 2'd0) ? (mindrv - 2'd1) : 2'd0;
    assign prev         = state_prev(s1_bi);

    // Only the input MSB matters in mono
    assign target = s1_vin[3];
    assign change = (target != prev);

    // Reversal mid-update only needs the frames already spent
    assign framecnt_2w = fastm_b2w_frames - framecnt + 6'd1;
    assign framecnt_2b = fastm_w2b_frames - framecnt + 6'd1;

    assign drive_to_input = target ? drive_white : drive_black;
    assign drive_prev     = prev ? drive_white : drive_black;

    always_comb begin
        if (framecnt != 6'd0) begin
            if (change && (mindrv == 2'd0)) begin
                // Reverse direction, cap reloads from the CSR
                fm_drive = drive_to_input;
                fm_bo    = {s1_bi[15:10], target ? framecnt_2w : framecnt_2b,
                            csr_mindrv, 1'b0, target};
            end else begin
                // Keep driving the colour already chosen
                fm_drive = drive_prev;
                fm_bo    = {s1_bi[15:10], framecnt_dec, mindrv_dec, s1_bi[1:0]};
            end
        end else if (change) begin
            // Idle pixel starts a full update
            fm_drive = drive_to_input;
            fm_bo    = {s1_bi[15:10], target ? fastm_b2w_frames : fastm_w2b_frames,
                        csr_mindrv, 1'b0, target};
        end else begin
            fm_drive = no_drive;
            fm_bo    = s1_bi;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pixel_writeback.sv
/*
 * Stage two of the pixel pipeline
 *   mode result select
 *   set-mode presets and init override
 *   output registers
 */
`default_nettype none

module pixel_writeback import pixel_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               s1_valid,
    input  wire base_mode_e   s1_base,
    input  wire op_state_e    s1_state,
    input  wire setmode_e     s1_param,
    input  wire [7:0]         s1_framecnt,
    input  wire               s1_set_mode_apply,
    input  wire pixel_state_t ml_bo,
    input  wire drive_e       ml_drive,
    input  wire pixel_state_t fm_bo,
    input  wire drive_e       fm_drive,
    output logic              out_valid,
    output pixel_state_t      proc_bo,
    output drive_e            proc_output
);

    pixel_state_t next_bo;
    drive_e       next_drive;

    always_comb begin
        // Normal operation, result of the active mode
        if (s1_base == base_manual_lut) begin
            next_bo    = ml_bo;
            next_drive = ml_drive;
        end else begin
            next_bo    = fm_bo;
            next_drive = fm_drive;
        end

        // Set-mode replaces the state word only
        if (s1_set_mode_apply) begin
            case (s1_param)
                setmode_ml_no_dither:  next_bo = default_state;
                setmode_ml_error_diff: next_bo = preset_ml_error_diff;
                setmode_fm_no_dither:  next_bo = preset_fm_no_dither;
                setmode_fm_bayer:      next_bo = preset_fm_bayer;
                setmode_fm_blue_noise: next_bo = preset_fm_blue_noise;
                // Invalid code, back to manual LUT
                default:               next_bo = default_state;
            endcase
        end

        // Init wins over everything
        // 128-frame round, counting down
        //   x111xxx  no drive
        //   1xxxxxx  black
        //   0xxxxxx  white
        if (s1_state == op_init) begin
            if (s1_framecnt[5:3] == 3'b111) begin
                next_drive = no_drive;
            end else if (s1_framecnt[6]) begin
                next_drive = drive_black;
            end else begin
                next_drive = drive_white;
            end
            next_bo = default_state;
        end
    end

    // Panel sees no drive between valid pixels
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            proc_output <= no_drive;
        end else begin
            out_valid   <= s1_valid;
            proc_output <= s1_valid ? next_drive : no_drive;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            proc_bo <= next_bo;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pixel_processing.sv
/*
 * Pixel update pipeline top level
 *   decode stage, manual LUT and fast mono units, writeback stage
 */
`default_nettype none

module pixel_processing import pixel_pkg::*; #(
    parameter frame_cnt_t fastm_b2w_frames = 6'd9,
    parameter frame_cnt_t fastm_w2b_frames = 6'd9
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               in_valid,
    // Pixel inputs
    input  wire pixel_val_t   proc_p_or,
    input  wire               proc_p_bd,
    input  wire               proc_p_n1,
    input  wire pixel_val_t   proc_p_e4,
    input  wire pixel_state_t proc_bi,
    input  wire drive_e       proc_lut_rd,
    // Operation inputs
    input  wire op_state_e    op_state,
    input  wire               op_valid,
    input  wire op_cmd_e      op_cmd,
    input  wire setmode_e     op_param,
    input  wire [7:0]         op_framecnt,
    // Static settings, held while pixels are in flight
    input  wire frame_cnt_t   csr_lutframe,
    input  wire mindrv_t      csr_mindrv,
    output wire               out_valid,
    output wire pixel_state_t proc_bo,
    output wire drive_e       proc_output
);

    wire               s1_valid;
    wire base_mode_e   s1_base;
    wire pixel_val_t   s1_vin;
    wire pixel_state_t s1_bi;
    wire drive_e       s1_lut_rd;
    wire op_state_e    s1_state;
    wire setmode_e     s1_param;
    wire [7:0]         s1_framecnt;
    wire               s1_force_clear;
    wire               s1_update_req;
    wire               s1_set_mode_apply;
    wire pixel_state_t ml_bo;
    wire drive_e       ml_drive;
    wire pixel_state_t fm_bo;
    wire drive_e       fm_drive;

    pixel_mode_decode pixel_mode_decode_inst (
        .clk, .rst_n, .in_valid,
        .proc_p_or, .proc_p_bd, .proc_p_n1, .proc_p_e4, .proc_bi, .proc_lut_rd,
        .op_state, .op_valid, .op_cmd, .op_param, .op_framecnt,
        .s1_valid, .s1_base, .s1_vin, .s1_bi, .s1_lut_rd, .s1_state, .s1_param,
        .s1_framecnt, .s1_force_clear, .s1_update_req, .s1_set_mode_apply
    );

    manual_lut_update manual_lut_update_inst (
        .s1_bi, .s1_vin, .s1_lut_rd, .s1_force_clear, .s1_update_req,
        .csr_lutframe, .ml_bo, .ml_drive
    );

    fast_mono_update #(
        .fastm_b2w_frames(fastm_b2w_frames),
        .fastm_w2b_frames(fastm_w2b_frames)
    ) fast_mono_update_inst (
        .s1_bi, .s1_vin, .csr_mindrv, .fm_bo, .fm_drive
    );

    pixel_writeback pixel_writeback_inst (
        .clk, .rst_n, .s1_valid, .s1_base, .s1_state, .s1_param, .s1_framecnt,
        .s1_set_mode_apply, .ml_bo, .ml_drive, .fm_bo, .fm_drive,
        .out_valid, .proc_bo, .proc_output
    );

endmodule

`default_nettype wire

//--- verification/pixel_processing_checker.sv
/*
 * Concurrent assertions on the pixel pipeline top level
 *   quiet output after reset, 2 cycle valid latency, legal drive codes
 */
`default_nettype none

module pixel_processing_checker (
    input wire       clk,
    input wire       rst_n,
    input wire       in_valid,
    input wire       out_valid,
    input wire [1:0] proc_output
);
    timeunit 1ns;
    timeprecision 1ps;

    // No pixel can reach the output within two cycles of reset
    reset_quiet: assert property (
        @(posedge clk) (!$past(rst_n, 1) || !$past(rst_n, 2)) |-> !out_valid
    ) else $error("out_valid high before a pixel could pass both stages");

    // Each strobe comes out exactly two stages later
    valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 1) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2))
    ) else $error("out_valid does not follow in_valid by 2 cycles");

    // Code 3 has no meaning on the panel
    drive_legal: assert property (
        @(posedge clk) disable iff (!rst_n) proc_output != 2'd3
    ) else $error("proc_output carries the unused drive code 3");

endmodule

bind pixel_processing pixel_processing_checker pixel_processing_checker_inst (
    .clk,
    .rst_n,
    .in_valid,
    .out_valid,
    .proc_output
);

`default_nettype wire

//--- verification/pixel_processing_tb.sv
/*
 * Testbench for the pixel update pipeline
 *   clock, reset and LCG stimulus on the falling edge
 *   reference model with queues of expected results
 *   directed and random tests, watchdog and error summary
 */
`default_nettype none

module pixel_processing_tb import pixel_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         clk_period    = 20;
    // Distinct frame counts so a swapped direction shows up
    localparam frame_cnt_t fm_b2w_frames = 6'd7;
    localparam frame_cnt_t fm_w2b_frames = 6'd11;
    // Set-mode, init sweep, manual LUT, fast mono, random
    localparam int         total_vectors = 9 + 128 + 24 + 36 + 256;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    pixel_val_t   proc_p_or;
    logic         proc_p_bd;
    logic         proc_p_n1;
    pixel_val_t   proc_p_e4;
    pixel_state_t proc_bi;
    drive_e       proc_lut_rd;
    op_state_e    op_state;
    logic         op_valid;
    op_cmd_e      op_cmd;
    setmode_e     op_param;
    logic [7:0]   op_framecnt;
    frame_cnt_t   csr_lutframe;
    mindrv_t      csr_mindrv;
    logic         out_valid;
    pixel_state_t proc_bo;
    drive_e       proc_output;

    // Pixels in flight with the oldest first
    pixel_state_t exp_bo_q[$];
    drive_e       exp_drv_q[$];
    string        name_q[$];
    int           issue_q[$];

    logic [31:0] lcg_state    = 32'd18;
    int          cycle        = 0;
    int          state_errors = 0;
    int          drive_errors = 0;
    int          other_errors = 0;

    pixel_processing #(
        .fastm_b2w_frames(fm_b2w_frames),
        .fastm_w2b_frames(fm_w2b_frames)
    ) pixel_processing_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Upper half of the LCG state has the better period
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // Expected drive and state word for the inputs now on the bus
    function automatic void model_pixel(output pixel_state_t bo, output drive_e drv);
        logic       is_ml;
        logic       set_mode;
        logic       clear;
        logic       apply;
        logic       tgt;
        logic       chg;
        dither_e    dth;
        pixel_val_t vin;
        frame_cnt_t cnt;
        frame_cnt_t frames;
        mindrv_t    cap;
        is_ml    = !proc_bi[15];
        set_mode = op_valid && (op_cmd == op_ext_setmode);
        clear    = (op_valid && (op_cmd == op_ext_redraw)) || (set_mode && op_framecnt != 8'd0);
        apply    = set_mode && (op_framecnt == 8'd0);
        // Every code that is not manual LUT, Bayer or blue noise is plain fast mono
        if (is_ml) begin
            dth = proc_bi[14] ? dither_ed_4bit : dither_none;
        end else if (proc_bi[15:12] == 4'd9) begin
            dth = dither_bayer;
        end else if (proc_bi[15:12] == 4'd10) begin
            dth = dither_bn_1bit;
        end else begin
            dth = dither_none;
        end
        if (clear) begin
            vin = (!is_ml && (op_framecnt[5] || (op_framecnt[4] && op_framecnt[3]))) ?
                  4'h0 : 4'hF;
        end else begin
            case (dth)
                dither_bayer:   vin = {4{proc_p_bd}};
                dither_bn_1bit: vin = {4{proc_p_n1}};
                dither_ed_4bit: vin = proc_p_e4;
                default:        vin = proc_p_or;
            endcase
        end
        cnt    = proc_bi[9:4];
        cap    = proc_bi[3:2];
        tgt    = vin[3];
        chg    = (tgt != proc_bi[0]);
        frames = tgt ? fm_b2w_frames : fm_w2b_frames;
        drv    = no_drive;
        bo     = proc_bi;
        if (is_ml) begin
            if (cnt != 6'd0) begin
                drv     = proc_lut_rd;
                bo[9:4] = cnt - 6'd1;
            end else if (clear) begin
                // Old target moves to the source field
                bo[13:10] = proc_bi[3:0];
                bo[9:4]   = csr_lutframe;
                bo[3:0]   = vin;
            end
        end else if (cnt != 6'd0 && !(chg && cap == 2'd0)) begin
            drv     = proc_bi[0] ? drive_white : drive_black;
            bo[9:4] = cnt - 6'd1;
            bo[3:2] = (cap == 2'd0) ? 2'd0 : cap - 2'd1;
        end else if (chg) begin
            drv     = tgt ? drive_white : drive_black;
            bo[9:4] = (cnt == 6'd0) ? frames : frames - cnt + 6'd1;
            bo[3:0] = {csr_mindrv, 1'b0, tgt};
        end
        if (apply) begin
            case (op_param)
                8'd1:    bo = 16'h400F;
                8'd2:    bo = 16'h8001;
                8'd3:    bo = 16'h9001;
                8'd4:    bo = 16'hA001;
                default: bo = 16'h000F;
            endcase
        end
        if (op_state == op_init) begin
            if (op_framecnt[5:3] == 3'b111) begin
                drv = no_drive;
            end else begin
                drv = op_framecnt[6] ? drive_black : drive_white;
            end
            bo = 16'h000F;
        end
    endfunction

    task automatic check_state(input string name, input pixel_state_t exp,
                               input pixel_state_t act);
        if (act !== exp) begin
            state_errors = state_errors + 1;
            $display("[FAIL] %s state expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_drive(input string name, input drive_e exp, input drive_e act);
        if (act !== exp) begin
            drive_errors = drive_errors + 1;
            $display("[FAIL] %s drive expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic drop_oldest();
        void'(exp_bo_q.pop_front());
        void'(exp_drv_q.pop_front());
        void'(name_q.pop_front());
        void'(issue_q.pop_front());
    endtask

    // Outputs are stable at the falling edge
    task automatic check_outputs();
        if (out_valid) begin
            if (name_q.size() == 0) begin
                other_errors = other_errors + 1;
                $display("out_valid was high at %0t with no pixel in flight", $time);
            end else begin
                if (cycle - issue_q[0] != 2) begin
                    other_errors = other_errors + 1;
                    $display("%s: result came %0d cycles after its input instead of 2",
                             name_q[0], cycle - issue_q[0]);
                end
                check_state(name_q[0], exp_bo_q[0], proc_bo);
                check_drive(name_q[0], exp_drv_q[0], proc_output);
                drop_oldest();
            end
        end else begin
            // Panel gets no drive while no result is valid
            check_drive("idle_output", no_drive, proc_output);
            if (name_q.size() != 0 && cycle - issue_q[0] >= 2) begin
                other_errors = other_errors + 1;
                $display("%s: out_valid did not rise 2 cycles after the input", name_q[0]);
                drop_oldest();
            end
        end
    endtask

    task automatic tick();
        @(negedge clk);
        cycle = cycle + 1;
        check_outputs();
    endtask

    // Valid pixel with random payload and no command
    task automatic random_inputs();
        logic [15:0] r;
        logic [15:0] r2;
        r           = next_rand();
        r2          = next_rand();
        in_valid    = 1'b1;
        proc_bi     = next_rand();
        proc_p_or   = r[3:0];
        proc_p_e4   = r[7:4];
        proc_p_bd   = r[8];
        proc_p_n1   = r[9];
        proc_lut_rd = drive_e'((r[11:10] == 2'd3) ? 2'd1 : r[11:10]);
        op_state    = op_normal;
        op_valid    = 1'b0;
        op_cmd      = op_cmd_e'(8'h00);
        op_param    = setmode_e'({5'd0, r[14:12]});
        op_framecnt = r2[7:0];
    endtask

    // Every dither source flips against the stored previous pixel
    task automatic invert_pixel_inputs();
        proc_p_or[3] = !proc_bi[0];
        proc_p_bd    = !proc_bi[0];
        proc_p_n1    = !proc_bi[0];
    endtask

    task automatic queue_expected(input string name);
        pixel_state_t bo;
        drive_e       drv;
        model_pixel(bo, drv);
        exp_bo_q.push_back(bo);
        exp_drv_q.push_back(drv);
        name_q.push_back(name);
        issue_q.push_back(cycle);
    endtask

    // Stop feeding and let the pipeline empty
    task automatic drain();
        tick();
        in_valid = 1'b0;
        while (name_q.size() != 0) begin
            tick();
        end
    endtask

    initial begin
        #(2 * (total_vectors + 10) * clk_period);
        $display("Timeout: the run did not finish in %0d clock periods",
                 2 * (total_vectors + 10));
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [15:0] r;
        logic [3:0]  fm_mode;
        rst_n = 1'b0;
        random_inputs();
        in_valid     = 1'b0;
        csr_lutframe = 6'd5;
        csr_mindrv   = 2'd0;
        repeat (3) tick();
        rst_n = 1'b1;

        // Presets for codes 0 to 4 and then invalid codes
        for (int i = 0; i < 9; i++) begin
            tick();
            random_inputs();
            op_valid    = 1'b1;
            op_cmd      = op_ext_setmode;
            op_framecnt = 8'd0;
            op_param    = setmode_e'((i < 5) ? 8'(i) : 8'(i * 37 + 5));
            queue_expected("setmode_preset");
        end
        drain();

        // Init pattern over a full 128 frame round
        for (int f = 0; f < 128; f++) begin
            tick();
            random_inputs();
            r           = next_rand();
            op_state    = op_init;
            op_valid    = r[0];
            op_cmd      = r[1] ? op_ext_redraw : op_ext_setmode;
            op_framecnt = 8'(f);
            queue_expected("init_override");
        end
        drain();

        // Manual LUT with no dither on even passes and error diffusion on odd ones
        csr_lutframe = 6'd23;
        for (int i = 0; i < 8; i++) begin
            tick();
            random_inputs();
            proc_bi  = {1'b0, i[0], proc_bi[13:10], 6'd0, proc_bi[3:0]};
            op_valid = 1'b1;
            op_cmd   = op_ext_redraw;
            queue_expected("ml_redraw_idle");
            tick();
            random_inputs();
            proc_bi = {1'b0, i[0], proc_bi[13:10], proc_bi[9:4] | 6'd1, proc_bi[3:0]};
            queue_expected("ml_lut_playback");
            tick();
            random_inputs();
            proc_bi     = {1'b0, i[0], proc_bi[13:10], 6'd0, proc_bi[3:0]};
            op_valid    = 1'b1;
            op_cmd      = op_ext_setmode;
            op_framecnt = op_framecnt | 8'h01;
            queue_expected("ml_setmode_clear");
        end
        drain();

        // Fast mono cycling through no dither, Bayer and blue noise
        csr_mindrv = 2'd2;
        for (int i = 0; i < 12; i++) begin
            fm_mode = 4'd8 + 4'(i % 3);
            tick();
            random_inputs();
            proc_bi = {fm_mode, proc_bi[11:10], 6'd0, proc_bi[3:0]};
            invert_pixel_inputs();
            queue_expected("fm_change_idle");
            tick();
            random_inputs();
            proc_bi = {fm_mode, proc_bi[11:10], proc_bi[9:4] | 6'd1,
                       proc_bi[3:2] | 2'd1, proc_bi[1:0]};
            invert_pixel_inputs();
            queue_expected("fm_change_capped");
            tick();
            random_inputs();
            // Steps of 8 walk op_framecnt bits 3 to 5
            proc_bi     = {fm_mode, proc_bi[11:10], 6'd0, proc_bi[3:0]};
            op_valid    = 1'b1;
            op_cmd      = op_ext_redraw;
            op_framecnt = 8'(i * 8);
            queue_expected("fm_clear_colour");
        end
        drain();

        // Back to back random pixels with CSRs changed only while empty
        for (int b = 0; b < 4; b++) begin
            r            = next_rand();
            csr_lutframe = r[5:0];
            csr_mindrv   = r[7:6];
            for (int i = 0; i < 64; i++) begin
                tick();
                random_inputs();
                r        = next_rand();
                op_valid = (r[1:0] == 2'd0);
                op_cmd   = op_cmd_e'({6'd0, r[3:2]});
                // Mostly normal states with some init and some reserved ones
                op_state = op_state_e'((r[7:5] == 3'd0) ? 2'd0 :
                                       ((r[7:5] == 3'd1) ? {1'b1, r[9]} : 2'd1));
                if (r[10] && r[11]) begin
                    op_framecnt = 8'd0;
                end
                queue_expected("random_mix");
            end
            drain();
        end

        $display("Errors: %0d state, %0d drive, %0d other",
                 state_errors, drive_errors, other_errors);
        if (state_errors + drive_errors + other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/pixel_pkg.sv
verilog/pixel_mode_decode.sv
verilog/manual_lut_update.sv
verilog/fast_mono_update.sv
verilog/pixel_writeback.sv
verilog/pixel_processing.sv
verification/pixel_processing_checker.sv
verification/pixel_processing_tb.sv

//--- Makefile
# Verilator build and run of the pixel pipeline testbench
TOP := pixel_processing_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on any error"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "All tests passed!" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
